//--- list.f
design/cp0_pkg.sv
design/mmu_pkg.sv
design/cp0_exc_prio.sv
design/cp0.sv
design/tlb.sv
design/cp0_mmu_top.sv
verification/cp0_mmu_tb.sv

//--- Makefile
TOP := cp0_mmu_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f list.f --top-module $(TOP) -o V$(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- verification/cp0_mmu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_mmu_tb;
	import cp0_pkg::*;
	import mmu_pkg::*;

	// row kinds
	localparam int K_WRITE  = 0;
	localparam int K_READ   = 1;
	localparam int K_SET    = 2;
	localparam int K_EXC    = 3;
	localparam int K_ERET   = 4;
	localparam int K_TLB    = 5;
	localparam int K_ACCEPT = 6;
	localparam int K_PEEK   = 7;

	// held inputs that a K_SET row changes
	localparam logic [7:0] SET_PC    = 8'd0;
	localparam logic [7:0] SET_VADDR = 8'd1;
	localparam logic [7:0] SET_CTRL  = 8'd2;
	localparam logic [7:0] SET_INT   = 8'd3;

	// outputs that a K_PEEK row samples
	localparam logic [7:0] PEEK_DPADDR = 8'd0;
	localparam logic [7:0] PEEK_DEXC   = 8'd1;
	localparam logic [7:0] PEEK_IPADDR = 8'd2;
	localparam logic [7:0] PEEK_IEXC   = 8'd3;

	// exception flags in struct order, fetch_adel on top
	localparam logic [31:0] F_FETCH = 32'h0000_0040;
	localparam logic [31:0] F_RI    = 32'h0000_0020;
	localparam logic [31:0] F_OV    = 32'h0000_0010;
	localparam logic [31:0] F_TRAP  = 32'h0000_0008;
	localparam logic [31:0] F_SYS   = 32'h0000_0004;
	localparam logic [31:0] F_LOAD  = 32'h0000_0002;
	localparam logic [31:0] F_STORE = 32'h0000_0001;
	localparam logic [31:0] F_SLOT  = 32'h0000_0100;
	localparam logic [31:0] F_WRITE = 32'h0000_0200;

	localparam logic [31:0] MASK_FULL    = 32'hFFFF_FFFF;
	localparam logic [31:0] MASK_INDEX   = 32'h0000_001F;
	localparam logic [31:0] MASK_LO      = 32'h3FFF_FFFF;
	localparam logic [31:0] MASK_CONTEXT = 32'hFF80_0000;
	// cu0, bev, im, um, erl, exl, ie
	localparam logic [31:0] MASK_STATUS  = 32'h1040_FF17;
	localparam logic [31:0] MASK_CODE    = 32'h0000_007C;
	localparam logic [31:0] MASK_BD      = 32'h8000_0000;
	localparam logic [31:0] MASK_EXL     = 32'h0000_0002;
	localparam logic [31:0] MASK_VPN2    = 32'hFFFF_E000;

	// vpn2 0x12 with asid 5, even page pfn 0xabc dirty, odd page pfn 0xdef clean
	localparam logic [31:0] HI_MAP  = 32'h0002_4005;
	localparam logic [31:0] HI_MISS = 32'h0004_6005;
	localparam logic [31:0] LO0_MAP = 32'h0002_AF06;
	localparam logic [31:0] LO1_MAP = 32'h0003_7BC2;

	localparam int RESET_CYCLES = 16;

	logic       clk;
	logic       reset;
	logic [7:0] ra;
	logic [7:0] wa;
	word_t      wd;
	logic       wen;
	logic       exc_raise;
	exc_flags_t exc_flags;
	word_t      pc;
	word_t      vaddr;
	logic       is_slot;
	logic       d_write;
	logic       eret;
	logic [5:0] ext_int;
	logic       int_accept;
	tlb_op_t    tlb_op;
	word_t      rd;
	word_t      epc;
	word_t      vector;
	logic       trap_taken;
	word_t      i_paddr;
	word_t      d_paddr;
	tlb_exc_t   i_tlb_exc;
	tlb_exc_t   d_tlb_exc;

	int          kind_q[$];
	logic [7:0]  addr_q[$];
	logic [31:0] data_q[$];
	logic [31:0] exp_q[$];
	string       name_q[$];
	logic [31:0] lcg_state = 32'd644;
	int          cycles = 0;
	int          cycle_limit = 0;

	cp0_mmu_top i_cp0_mmu_top (
		.clk        (clk),
		.reset      (reset),
		.ra         (ra),
		.rd         (rd),
		.wa         (wa),
		.wd         (wd),
		.wen        (wen),
		.exc_raise  (exc_raise),
		.exc_flags  (exc_flags),
		.pc         (pc),
		.vaddr      (vaddr),
		.is_slot    (is_slot),
		.d_write    (d_write),
		.eret       (eret),
		.ext_int    (ext_int),
		.int_accept (int_accept),
		.tlb_op     (tlb_op),
		.epc        (epc),
		.vector     (vector),
		.trap_taken (trap_taken),
		.i_paddr    (i_paddr),
		.d_paddr    (d_paddr),
		.i_tlb_exc  (i_tlb_exc),
		.d_tlb_exc  (d_tlb_exc)
	);

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// excode sits in cause bits 6:2
	function automatic logic [31:0] code_field(input exc_code_t code);
		return {25'd0, code, 2'd0};
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("error %s: expected %h, actual %h", name, expected, actual);
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
	endtask

	task automatic add_row(input int kind, input logic [7:0] addr, input logic [31:0] data,
		input logic [31:0] expected, input string name);
		kind_q.push_back(kind);
		addr_q.push_back(addr);
		data_q.push_back(data);
		exp_q.push_back(expected);
		name_q.push_back(name);
	endtask

	task automatic add_write_read(input logic [7:0] addr, input logic [31:0] word,
		input logic [31:0] mask, input string name);
		add_row(K_WRITE, addr, word, 32'd0, name);
		add_row(K_READ, addr, MASK_FULL, word & mask, name);
	endtask

	// raise one exception, read its code and optionally BadVAddr, then return
	task automatic add_priority(input logic [31:0] flags, input exc_code_t code,
		input logic check_bad, input logic [31:0] bad, input string name);
		add_row(K_SET, SET_CTRL, flags, 32'd0, name);
		add_row(K_EXC, 8'd0, 32'd0, 32'd1, name);
		add_row(K_READ, REG_CAUSE, MASK_CODE, code_field(code), name);
		if (check_bad) begin
			add_row(K_READ, REG_BAD_VADDR, MASK_FULL, bad, name);
		end
		add_row(K_ERET, 8'd0, 32'd0, 32'd0, name);
	endtask

	task automatic build_table();
		// register writes and masks
		add_write_read(REG_INDEX, lcg_next(), MASK_INDEX, "index write");
		add_write_read(REG_ENTRY_LO0, lcg_next(), MASK_LO, "entry_lo0 write");
		add_write_read(REG_ENTRY_LO1, lcg_next(), MASK_LO, "entry_lo1 write");
		add_write_read(REG_CONTEXT, lcg_next(), MASK_CONTEXT, "context write");
		add_write_read(REG_COMPARE, lcg_next(), MASK_FULL, "compare write");
		add_write_read(REG_STATUS, lcg_next(), MASK_STATUS, "status write");
		add_write_read(REG_EPC, lcg_next(), MASK_FULL, "epc write");
		add_row(K_WRITE, REG_PRID, lcg_next(), 32'd0, "prid write");
		add_row(K_READ, REG_PRID, MASK_FULL, PRID_RESET, "prid read only");
		add_row(K_WRITE, REG_CONFIG1, lcg_next(), 32'd0, "config1 write");
		add_row(K_READ, REG_CONFIG1, MASK_FULL, CONFIG1_RESET, "config1 read only");
		add_write_read(REG_STATUS, 32'd0, MASK_STATUS, "status clear");

		// syscall, then a nested one, then eret
		add_row(K_SET, SET_PC, 32'h8000_0200, 32'd0, "pc");
		add_row(K_SET, SET_CTRL, F_SYS, 32'd0, "syscall flags");
		add_row(K_EXC, 8'd0, 32'd0, 32'd1, "syscall trap");
		add_row(K_READ, REG_EPC, MASK_FULL, 32'h8000_0200, "syscall epc");
		add_row(K_READ, REG_CAUSE, MASK_BD | MASK_CODE, code_field(EXC_SYS), "syscall cause");
		add_row(K_READ, REG_STATUS, MASK_EXL, MASK_EXL, "syscall exl");
		add_row(K_SET, SET_PC, 32'h8000_0300, 32'd0, "pc");
		add_row(K_EXC, 8'd0, 32'd0, 32'd1, "nested trap");
		add_row(K_READ, REG_EPC, MASK_FULL, 32'h8000_0200, "nested epc kept");
		add_row(K_ERET, 8'd0, 32'd0, 32'd0, "eret");
		add_row(K_READ, REG_STATUS, MASK_EXL, 32'd0, "eret clears exl");
		// syscall in a delay slot
		add_row(K_SET, SET_PC, 32'h8000_0404, 32'd0, "pc");
		add_row(K_SET, SET_CTRL, F_SYS | F_SLOT, 32'd0, "slot flags");
		add_row(K_EXC, 8'd0, 32'd0, 32'd1, "slot trap");
		add_row(K_READ, REG_EPC, MASK_FULL, 32'h8000_0400, "slot epc");
		add_row(K_READ, REG_CAUSE, MASK_BD | MASK_CODE, MASK_BD | code_field(EXC_SYS),
			"slot cause");
		add_row(K_READ, REG_STATUS, MASK_EXL, MASK_EXL, "slot exl");
		add_row(K_ERET, 8'd0, 32'd0, 32'd0, "eret");
		add_row(K_READ, REG_STATUS, MASK_EXL, 32'd0, "slot eret clears exl");

		// priority, with kseg0 addresses so the TLB stays quiet
		add_row(K_SET, SET_PC, 32'h8000_0101, 32'd0, "pc");
		add_row(K_SET, SET_VADDR, 32'h8000_2003, 32'd0, "vaddr");
		add_priority(F_FETCH | F_RI | F_SYS | F_STORE, EXC_ADEL, 1'b1, 32'h8000_0101,
			"fetch adel first");
		add_priority(F_RI | F_OV | F_TRAP, EXC_RI, 1'b0, 32'd0, "ri over ov");
		add_priority(F_OV | F_TRAP | F_SYS, EXC_OV, 1'b0, 32'd0, "ov over trap");
		add_priority(F_TRAP | F_SYS | F_LOAD, EXC_BP, 1'b0, 32'd0, "trap over sys");
		add_priority(F_SYS | F_LOAD | F_STORE, EXC_SYS, 1'b0, 32'd0, "sys over load");
		add_priority(F_LOAD | F_STORE, EXC_ADEL, 1'b1, 32'h8000_2003, "load adel");
		add_row(K_SET, SET_VADDR, 32'h8000_3007, 32'd0, "vaddr");
		add_priority(F_STORE, EXC_ADES, 1'b1, 32'h8000_3007, "store ades");

		// tlbwi into index 3, clear, tlbr
		add_row(K_SET, SET_CTRL, 32'd0, 32'd0, "flags clear");
		add_write_read(REG_INDEX, 32'd3, MASK_INDEX, "tlb index");
		add_write_read(REG_ENTRY_HI, HI_MAP, MASK_FULL, "tlb entry_hi");
		add_row(K_WRITE, REG_ENTRY_LO0, LO0_MAP, 32'd0, "tlb entry_lo0");
		add_row(K_WRITE, REG_ENTRY_LO1, LO1_MAP, 32'd0, "tlb entry_lo1");
		add_row(K_TLB, 8'd0, 32'(TLB_WRITE_INDEXED), 32'd0, "tlbwi");
		add_row(K_WRITE, REG_ENTRY_HI, 32'd0, 32'd0, "clear entry_hi");
		add_row(K_WRITE, REG_ENTRY_LO0, 32'd0, 32'd0, "clear entry_lo0");
		add_write_read(REG_ENTRY_LO1, 32'd0, MASK_LO, "clear entry_lo1");
		add_row(K_TLB, 8'd0, 32'(TLB_READ), 32'd0, "tlbr");
		add_row(K_READ, REG_ENTRY_HI, MASK_FULL, HI_MAP, "tlbr entry_hi");
		add_row(K_READ, REG_ENTRY_LO0, MASK_FULL, LO0_MAP, "tlbr entry_lo0");
		add_row(K_READ, REG_ENTRY_LO1, MASK_FULL, LO1_MAP, "tlbr entry_lo1");
		// probe hit and miss
		add_row(K_WRITE, REG_INDEX, 32'd0, 32'd0, "index clear");
		add_row(K_TLB, 8'd0, 32'(TLB_PROBE), 32'd0, "tlbp");
		add_row(K_READ, REG_INDEX, MASK_FULL, 32'd3, "tlbp hit index");
		add_row(K_WRITE, REG_ENTRY_HI, HI_MISS, 32'd0, "entry_hi miss");
		add_row(K_TLB, 8'd0, 32'(TLB_PROBE), 32'd0, "tlbp");
		add_row(K_READ, REG_INDEX, MASK_BD, MASK_BD, "tlbp miss bit");
		add_row(K_WRITE, REG_ENTRY_HI, HI_MAP, 32'd0, "entry_hi restore");
		// mapped translations
		add_row(K_SET, SET_VADDR, 32'h0002_4123, 32'd0, "vaddr");
		add_row(K_PEEK, PEEK_DPADDR, MASK_FULL, 32'h00AB_C123, "even page paddr");
		add_row(K_PEEK, PEEK_DEXC, 32'h7, 32'd0, "even page no fault");
		add_row(K_SET, SET_VADDR, 32'h0002_5456, 32'd0, "vaddr");
		add_row(K_PEEK, PEEK_DPADDR, MASK_FULL, 32'h00DE_F456, "odd page paddr");
		// fetch side through the same entry, then a miss, then kseg0
		add_row(K_SET, SET_PC, 32'h0002_5ABC, 32'd0, "pc");
		add_row(K_PEEK, PEEK_IPADDR, MASK_FULL, 32'h00DE_FABC, "fetch odd page paddr");
		add_row(K_PEEK, PEEK_IEXC, 32'h7, 32'd0, "fetch no fault");
		add_row(K_SET, SET_PC, 32'h0040_0000, 32'd0, "pc");
		add_row(K_PEEK, PEEK_IEXC, 32'h7, 32'h4, "fetch refill");
		add_row(K_SET, SET_PC, 32'h8000_0101, 32'd0, "pc");
		add_row(K_PEEK, PEEK_IPADDR, MASK_FULL, 32'h0000_0101, "kseg0 fetch paddr");
		add_row(K_PEEK, PEEK_IEXC, 32'h7, 32'd0, "kseg0 fetch no fault");
		add_row(K_SET, SET_CTRL, F_WRITE, 32'd0, "store");
		add_row(K_PEEK, PEEK_DEXC, 32'h7, 32'h1, "clean page store modified");
		// refill, store then load
		add_row(K_SET, SET_VADDR, 32'h0040_0010, 32'd0, "vaddr");
		add_row(K_PEEK, PEEK_DEXC, 32'h7, 32'h4, "unmapped refill");
		add_priority(F_WRITE, EXC_TLBS, 1'b1, 32'h0040_0010, "refill store");
		add_row(K_READ, REG_ENTRY_HI, MASK_VPN2, 32'h0040_0000, "refill vpn2");
		add_row(K_SET, SET_VADDR, 32'h0060_0020, 32'd0, "vaddr");
		add_priority(32'd0, EXC_TLBL, 1'b1, 32'h0060_0020, "refill load");
		add_row(K_READ, REG_ENTRY_HI, MASK_VPN2, 32'h0060_0000, "refill load vpn2");
		// kseg1 bypass
		add_row(K_SET, SET_VADDR, 32'hA012_3456, 32'd0, "vaddr");
		add_row(K_PEEK, PEEK_DPADDR, MASK_FULL, 32'h0012_3456, "kseg1 paddr");
		add_row(K_PEEK, PEEK_DEXC, 32'h7, 32'd0, "kseg1 no fault");
		add_row(K_SET, SET_VADDR, 32'h8000_0000, 32'd0, "vaddr");

		// external line 0 through im2, held off, then latched and taken
		add_write_read(REG_STATUS, 32'h0000_0401, MASK_STATUS, "status ie im2");
		add_row(K_SET, SET_INT, 32'h01, 32'd0, "ext_int 0 high");
		add_row(K_ACCEPT, 8'd0, 32'd0, 32'd0, "interrupt held off");
		add_row(K_SET, SET_INT, 32'd0, 32'd0, "ext_int low");
		add_row(K_ACCEPT, 8'd0, 32'd0, 32'd0, "interrupt still held off");
		add_row(K_ACCEPT, 8'd0, 32'd1, 32'd1, "latched interrupt taken");
		add_row(K_READ, REG_CAUSE, MASK_CODE, code_field(EXC_INT), "interrupt code");
		add_row(K_READ, REG_STATUS, MASK_EXL, MASK_EXL, "interrupt exl");
		add_row(K_ERET, 8'd0, 32'd0, 32'd0, "eret");
		// software interrupt 0
		add_row(K_WRITE, REG_STATUS, 32'h0000_0101, 32'd0, "status ie im0");
		add_row(K_WRITE, REG_CAUSE, 32'h0000_0100, 32'd0, "cause ip0");
		add_row(K_ACCEPT, 8'd0, 32'd0, 32'd0, "software held off");
		add_row(K_ACCEPT, 8'd0, 32'd1, 32'd1, "software taken");
		add_row(K_READ, REG_CAUSE, MASK_CODE, code_field(EXC_INT), "software code");
		add_row(K_WRITE, REG_CAUSE, 32'd0, 32'd0, "cause clear");
		add_row(K_ERET, 8'd0, 32'd0, 32'd0, "eret");
		// line 1 is not enabled
		add_row(K_WRITE, REG_STATUS, 32'h0000_0401, 32'd0, "status ie im2");
		add_row(K_SET, SET_INT, 32'h02, 32'd0, "ext_int 1 high");
		add_row(K_ACCEPT, 8'd0, 32'd1, 32'd0, "masked line");
		add_row(K_ACCEPT, 8'd0, 32'd1, 32'd0, "masked line again");
		add_row(K_SET, SET_INT, 32'd0, 32'd0, "ext_int low");
	endtask

	task automatic run_row(input int r);
		logic [31:0] data;
		logic [31:0] actual;
		data = data_q[r];
		@(posedge clk);
		#1;
		wen        = 1'b0;
		exc_raise  = 1'b0;
		eret       = 1'b0;
		int_accept = 1'b0;
		tlb_op     = TLB_NONE;
		case (kind_q[r])
			K_WRITE: begin
				wa  = addr_q[r];
				wd  = data;
				wen = 1'b1;
			end
			K_READ: ra = addr_q[r];
			K_SET: begin
				case (addr_q[r])
					SET_PC:    pc = data;
					SET_VADDR: vaddr = data;
					SET_CTRL: begin
						exc_flags = exc_flags_t'(data[6:0]);
						is_slot   = data[8];
						d_write   = data[9];
					end
					default:   ext_int = data[5:0];
				endcase
			end
			K_EXC:    exc_raise = 1'b1;
			K_ERET:   eret = 1'b1;
			K_TLB:    tlb_op = tlb_op_t'(data[1:0]);
			K_ACCEPT: int_accept = data[0];
			default: ;
		endcase
		// combinational outputs are settled by the falling edge
		@(negedge clk);
		case (kind_q[r])
			K_READ: begin
				check_value(name_q[r], exp_q[r], rd & data);
				// the epc port mirrors the register
				if (addr_q[r] == REG_EPC) begin
					check_value(name_q[r], exp_q[r], epc & data);
				end
			end
			K_EXC: begin
				check_value(name_q[r], exp_q[r], {31'd0, trap_taken});
				check_value(name_q[r], EXC_VECTOR, vector);
			end
			K_ACCEPT: check_value(name_q[r], exp_q[r], {31'd0, trap_taken});
			K_PEEK: begin
				case (addr_q[r])
					PEEK_DPADDR: actual = d_paddr;
					PEEK_DEXC:   actual = {29'd0, d_tlb_exc};
					PEEK_IPADDR: actual = i_paddr;
					default:     actual = {29'd0, i_tlb_exc};
				endcase
				check_value(name_q[r], exp_q[r], actual & data);
			end
			default: ;
		endcase
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout: the tests did not finish within %0d cycles", cycle_limit);
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
	end

	initial begin
		reset      = 1'b1;
		ra         = 8'd0;
		wa         = 8'd0;
		wd         = '0;
		wen        = 1'b0;
		exc_raise  = 1'b0;
		exc_flags  = '0;
		pc         = 32'h8000_0100;
		vaddr      = 32'h8000_0000;
		is_slot    = 1'b0;
		d_write    = 1'b0;
		eret       = 1'b0;
		ext_int    = 6'd0;
		int_accept = 1'b0;
		tlb_op     = TLB_NONE;
		build_table();
		cycle_limit = kind_q.size() * 4 + RESET_CYCLES;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int r = 0; r < kind_q.size(); r++) begin
			run_row(r);
		end
		@(posedge clk);
		#1;
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- design/cp0_mmu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_mmu_top (
	input  logic                clk,
	input  logic                reset,
	input  logic [7:0]          ra,
	output cp0_pkg::word_t      rd,
	input  logic [7:0]          wa,
	input  cp0_pkg::word_t      wd,
	input  logic                wen,
	input  logic                exc_raise,
	input  cp0_pkg::exc_flags_t exc_flags,
	input  cp0_pkg::word_t      pc,
	input  cp0_pkg::word_t      vaddr,
	input  logic                is_slot,
	input  logic                d_write,
	input  logic                eret,
	input  logic [5:0]          ext_int,
	input  logic                int_accept,
	input  mmu_pkg::tlb_op_t    tlb_op,
	output cp0_pkg::word_t      epc,
	output cp0_pkg::word_t      vector,
	output logic                trap_taken,
	output cp0_pkg::word_t      i_paddr,
	output cp0_pkg::word_t      d_paddr,
	output mmu_pkg::tlb_exc_t   i_tlb_exc,
	output mmu_pkg::tlb_exc_t   d_tlb_exc
);
	import cp0_pkg::*;
	import mmu_pkg::*;

	cp0_regs_t regs;
	mmu_resp_t mmu_resp;
	exc_code_t exc_code;
	word_t     fault_addr;
	logic      fault_valid;
	logic      interrupt_pending;

	cp0 i_cp0 (
		.clk               (clk),
		.reset             (reset),
		.ra                (ra),
		.wa                (wa),
		.wd                (wd),
		.wen               (wen),
		.eret              (eret),
		.exc_raise         (exc_raise),
		.is_slot           (is_slot),
		.int_accept        (int_accept),
		.ext_int           (ext_int),
		.pc                (pc),
		.exc_code          (exc_code),
		.fault_addr        (fault_addr),
		.fault_valid       (fault_valid),
		.tlb_op            (tlb_op),
		.mmu_resp          (mmu_resp),
		.rd                (rd),
		.epc               (epc),
		.vector            (vector),
		.regs              (regs),
		.interrupt_pending (interrupt_pending),
		.trap_taken        (trap_taken)
	);

	cp0_exc_prio i_cp0_exc_prio (
		.interrupt_pending (interrupt_pending),
		.exc_flags         (exc_flags),
		.i_tlb_exc         (i_tlb_exc),
		.d_tlb_exc         (d_tlb_exc),
		.d_write           (d_write),
		.pc                (pc),
		.vaddr             (vaddr),
		.exc_code          (exc_code),
		.fault_addr        (fault_addr),
		.fault_valid       (fault_valid)
	);

	// fetch looks up pc, the data side looks up vaddr
	tlb #(
		.ENTRIES (TLB_ENTRIES)
	) i_tlb (
		.clk       (clk),
		.reset     (reset),
		.regs      (regs),
		.tlb_op    (tlb_op),
		.i_vaddr   (pc),
		.d_vaddr   (vaddr),
		.d_write   (d_write),
		.i_paddr   (i_paddr),
		.d_paddr   (d_paddr),
		.i_tlb_exc (i_tlb_exc),
		.d_tlb_exc (d_tlb_exc),
		.mmu_resp  (mmu_resp)
	);

endmodule

`default_nettype wire

//--- design/tlb.sv
`timescale 1ns/1ps
`default_nettype none

module tlb #(
	parameter int ENTRIES = mmu_pkg::TLB_ENTRIES
) (
	input  logic               clk,
	input  logic               reset,
	input  cp0_pkg::cp0_regs_t regs,
	input  mmu_pkg::tlb_op_t   tlb_op,
	input  cp0_pkg::word_t     i_vaddr,
	input  cp0_pkg::word_t     d_vaddr,
	input  logic               d_write,
	output cp0_pkg::word_t     i_paddr,
	output cp0_pkg::word_t     d_paddr,
	output mmu_pkg::tlb_exc_t  i_tlb_exc,
	output mmu_pkg::tlb_exc_t  d_tlb_exc,
	output mmu_pkg::mmu_resp_t mmu_resp
);
	import cp0_pkg::*;
	import mmu_pkg::*;

	localparam int IDX_W = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

	typedef struct packed {
		word_t    paddr;
		tlb_exc_t exc;
	} xlate_t;

	tlb_entry_t       entries [ENTRIES];
	tlb_entry_t       rd_entry;
	tlb_entry_t       wr_entry;
	logic [IDX_W-1:0] idx;
	logic [7:0]       asid;
	xlate_t           i_xlate;
	xlate_t           d_xlate;

	assign idx  = regs.index[IDX_W-1:0];
	assign asid = regs.entry_hi[7:0];

	function automatic logic hit_entry(input tlb_entry_t e, input logic [18:0] vpn2,
		input logic [7:0] id);
		return (e.vpn2 == vpn2) && (e.g || e.asid == id);
	endfunction

	function automatic xlate_t translate(input word_t va, input logic write);
		xlate_t     res;
		tlb_entry_t e;
		logic       hit;
		logic [19:0] pfn;
		logic       v;
		logic       d;
		hit = 1'b0;
		e   = '0;
		for (int i = 0; i < ENTRIES; i++) begin
			if (hit_entry(entries[i], va[31:13], asid)) begin
				hit = 1'b1;
				e   = entries[i];
			end
		end
		// bit 12 picks the odd page of the pair
		pfn = va[12] ? e.pfn1 : e.pfn0;
		v   = va[12] ? e.v1 : e.v0;
		d   = va[12] ? e.d1 : e.d0;
		res.paddr        = {pfn, va[11:0]};
		res.exc.refill   = ~hit;
		res.exc.invalid  = hit & ~v;
		res.exc.modified = hit & v & write & ~d;
		// kseg0 and kseg1 are unmapped
		if (va[31:30] == 2'b10) begin
			res.paddr = {3'b000, va[28:0]};
			res.exc   = '0;
		end
		return res;
	endfunction

	// lookups also follow the entry array and the current asid
	always_comb begin
		i_xlate = translate(i_vaddr, 1'b0);
		d_xlate = translate(d_vaddr, d_write);
	end

	assign i_paddr   = i_xlate.paddr;
	assign i_tlb_exc = i_xlate.exc;
	assign d_paddr   = d_xlate.paddr;
	assign d_tlb_exc = d_xlate.exc;

	assign rd_entry = entries[idx];

	always_comb begin
		mmu_resp.miss  = 1'b1;
		mmu_resp.index = '0;
		for (int i = 0; i < ENTRIES; i++) begin
			if (hit_entry(entries[i], regs.entry_hi[31:13], asid)) begin
				mmu_resp.miss  = 1'b0;
				mmu_resp.index = 5'(i);
			end
		end
		mmu_resp.entry_hi  = {rd_entry.vpn2, 5'd0, rd_entry.asid};
		mmu_resp.entry_lo0 = {6'd0, rd_entry.pfn0, 3'd0, rd_entry.d0, rd_entry.v0, rd_entry.g};
		mmu_resp.entry_lo1 = {6'd0, rd_entry.pfn1, 3'd0, rd_entry.d1, rd_entry.v1, rd_entry.g};
	end

	always_comb begin
		wr_entry.vpn2 = regs.entry_hi[31:13];
		wr_entry.asid = regs.entry_hi[7:0];
		// global only when both halves say so
		wr_entry.g    = regs.entry_lo0[0] & regs.entry_lo1[0];
		wr_entry.pfn0 = regs.entry_lo0[25:6];
		wr_entry.d0   = regs.entry_lo0[2];
		wr_entry.v0   = regs.entry_lo0[1];
		wr_entry.pfn1 = regs.entry_lo1[25:6];
		wr_entry.d1   = regs.entry_lo1[2];
		wr_entry.v1   = regs.entry_lo1[1];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < ENTRIES; i++) begin
				entries[i] <= '0;
			end
		end else if (tlb_op == TLB_WRITE_INDEXED) begin
			entries[idx] <= wr_entry;
		end
	end

endmodule

`default_nettype wire

//--- design/cp0.sv
`timescale 1ns/1ps
`default_nettype none

module cp0 (
	input  logic               clk,
	input  logic               reset,
	input  logic [7:0]         ra,
	input  logic [7:0]         wa,
	input  cp0_pkg::word_t     wd,
	input  logic               wen,
	input  logic               eret,
	input  logic               exc_raise,
	input  logic               is_slot,
	input  logic               int_accept,
	input  logic [5:0]         ext_int,
	input  cp0_pkg::word_t     pc,
	input  cp0_pkg::exc_code_t exc_code,
	input  cp0_pkg::word_t     fault_addr,
	input  logic               fault_valid,
	input  mmu_pkg::tlb_op_t   tlb_op,
	input  mmu_pkg::mmu_resp_t mmu_resp,
	output cp0_pkg::word_t     rd,
	output cp0_pkg::word_t     epc,
	output cp0_pkg::word_t     vector,
	output cp0_pkg::cp0_regs_t regs,
	output logic               interrupt_pending,
	output logic               trap_taken
);
	import cp0_pkg::*;
	import mmu_pkg::*;

	cp0_regs_t  regs_nxt;
	logic       count_tick;
	logic       int_latched;
	logic       int_now;
	logic [7:0] hw_ip;

	function automatic word_t merge(input word_t old, input word_t val, input word_t mask);
		return (old & ~mask) | (val & mask);
	endfunction

	// timer shares ip7 with the top external line
	assign hw_ip   = {ext_int[5] | regs.cause.ti, ext_int[4:0], regs.cause.ip[1:0]};
	assign int_now = regs.status.ie & ~regs.status.exl & ~regs.status.erl &
		(|(hw_ip & regs.status.im));

	assign interrupt_pending = int_now | int_latched;
	assign trap_taken        = exc_raise | (int_accept & interrupt_pending);
	assign vector            = EXC_VECTOR;
	assign epc               = regs.epc;

	always_ff @(posedge clk) begin
		if (reset) begin
			regs         <= '0;
			regs.prid    <= PRID_RESET;
			regs.config0 <= CONFIG0_RESET;
			regs.config1 <= CONFIG1_RESET;
			count_tick   <= 1'b0;
			int_latched  <= 1'b0;
		end else begin
			regs       <= regs_nxt;
			count_tick <= ~count_tick;
			// hold an interrupt until the pipeline takes it
			if (trap_taken) begin
				int_latched <= 1'b0;
			end else if (int_now) begin
				int_latched <= 1'b1;
			end
		end
	end

	always_comb begin
		unique case (ra)
			REG_INDEX:     rd = regs.index;
			REG_ENTRY_LO0: rd = regs.entry_lo0;
			REG_ENTRY_LO1: rd = regs.entry_lo1;
			REG_CONTEXT:   rd = regs.context_;
			REG_PAGE_MASK: rd = regs.page_mask;
			REG_BAD_VADDR: rd = regs.bad_vaddr;
			REG_COUNT:     rd = regs.count;
			REG_ENTRY_HI:  rd = regs.entry_hi;
			REG_COMPARE:   rd = regs.compare;
			REG_STATUS:    rd = regs.status;
			REG_CAUSE:     rd = regs.cause;
			REG_EPC:       rd = regs.epc;
			REG_PRID:      rd = regs.prid;
			REG_CONFIG0:   rd = regs.config0;
			REG_CONFIG1:   rd = regs.config1;
			default:       rd = '0;
		endcase
	end

	always_comb begin
		regs_nxt = regs;
		regs_nxt.cause.ip[7:2] = ext_int;

		// count advances every other cycle
		if (count_tick && !(wen && wa == REG_COUNT)) begin
			regs_nxt.count = regs.count + 32'd1;
			if (regs.count + 32'd1 == regs.compare) begin
				regs_nxt.cause.ti = 1'b1;
			end
		end

		if (trap_taken) begin
			if (fault_valid) begin
				regs_nxt.bad_vaddr          = fault_addr;
				regs_nxt.entry_hi[31:13]    = fault_addr[31:13];
			end
			regs_nxt.cause.exc_code = exc_code;
			// nested exceptions keep the first epc
			if (!regs.status.exl) begin
				regs_nxt.cause.bd = is_slot;
				regs_nxt.epc      = is_slot ? pc - 32'd4 : pc;
			end
			regs_nxt.status.exl = 1'b1;
		end else begin
			if (wen) begin
				unique case (wa)
					REG_INDEX:
						regs_nxt.index = merge(regs_nxt.index, wd, WMASK_INDEX);
					REG_ENTRY_LO0:
						regs_nxt.entry_lo0 = merge(regs_nxt.entry_lo0, wd, WMASK_ENTRY_LO);
					REG_ENTRY_LO1:
						regs_nxt.entry_lo1 = merge(regs_nxt.entry_lo1, wd, WMASK_ENTRY_LO);
					REG_CONTEXT:
						regs_nxt.context_ = merge(regs_nxt.context_, wd, WMASK_CONTEXT);
					REG_COUNT:
						regs_nxt.count = wd;
					REG_ENTRY_HI:
						regs_nxt.entry_hi = merge(regs_nxt.entry_hi, wd, WMASK_ENTRY_HI);
					REG_COMPARE: begin
						regs_nxt.compare  = wd;
						// writing compare acknowledges the timer
						regs_nxt.cause.ti = 1'b0;
					end
					REG_STATUS:
						regs_nxt.status = merge(regs_nxt.status, wd, WMASK_STATUS);
					REG_CAUSE:
						regs_nxt.cause = merge(regs_nxt.cause, wd, WMASK_CAUSE);
					REG_EPC:
						regs_nxt.epc = wd;
					REG_CONFIG0:
						regs_nxt.config0 = merge(regs_nxt.config0, wd, WMASK_CONFIG0);
					default: ;
				endcase
			end
			unique case (tlb_op)
				TLB_PROBE:
					regs_nxt.index = {mmu_resp.miss, 26'd0, mmu_resp.index};
				TLB_READ: begin
					regs_nxt.entry_hi  = mmu_resp.entry_hi;
					regs_nxt.entry_lo0 = mmu_resp.entry_lo0;
					regs_nxt.entry_lo1 = mmu_resp.entry_lo1;
				end
				default: ;
			endcase
		end

		if (eret) begin
			regs_nxt.status.exl = 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- design/cp0_exc_prio.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_exc_prio (
	input  logic                interrupt_pending,
	input  cp0_pkg::exc_flags_t exc_flags,
	input  mmu_pkg::tlb_exc_t   i_tlb_exc,
	input  mmu_pkg::tlb_exc_t   d_tlb_exc,
	input  logic                d_write,
	input  cp0_pkg::word_t      pc,
	input  cp0_pkg::word_t      vaddr,
	output cp0_pkg::exc_code_t  exc_code,
	output cp0_pkg::word_t      fault_addr,
	output logic                fault_valid
);
	import cp0_pkg::*;

	logic i_tlb_fault;
	logic d_tlb_fault;

	// fetch side never sees a modified fault
	assign i_tlb_fault = i_tlb_exc.refill | i_tlb_exc.invalid;
	assign d_tlb_fault = d_tlb_exc.refill | d_tlb_exc.invalid | d_tlb_exc.modified;

	always_comb begin
		exc_code    = EXC_INT;
		fault_addr  = pc;
		fault_valid = 1'b0;
		if (interrupt_pending) begin
			exc_code = EXC_INT;
		end else if (exc_flags.fetch_adel) begin
			exc_code    = EXC_ADEL;
			fault_valid = 1'b1;
		end else if (exc_flags.ri) begin
			exc_code = EXC_RI;
		end else if (i_tlb_fault) begin
			exc_code    = EXC_TLBL;
			fault_valid = 1'b1;
		end else if (exc_flags.ov) begin
			exc_code = EXC_OV;
		end else if (exc_flags.trap) begin
			exc_code = EXC_BP;
		end else if (exc_flags.sys) begin
			exc_code = EXC_SYS;
		end else if (d_tlb_fault) begin
			// stores and dirty-bit faults report as TLBS
			exc_code    = (d_tlb_exc.modified || d_write) ? EXC_TLBS : EXC_TLBL;
			fault_addr  = vaddr;
			fault_valid = 1'b1;
		end else if (exc_flags.load_adel) begin
			exc_code    = EXC_ADEL;
			fault_addr  = vaddr;
			fault_valid = 1'b1;
		end else if (exc_flags.store_ades) begin
			exc_code    = EXC_ADES;
			fault_addr  = vaddr;
			fault_valid = 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- design/mmu_pkg.sv
`default_nettype none

package mmu_pkg;

	localparam int TLB_ENTRIES = 8;

	// one entry maps an even/odd pair of 4 KiB pages
	typedef struct packed {
		logic [18:0] vpn2;
		logic [7:0]  asid;
		// global, matches any asid
		logic        g;
		logic [19:0] pfn0;
		logic        d0;
		logic        v0;
		logic [19:0] pfn1;
		logic        d1;
		logic        v1;
	} tlb_entry_t;

	typedef enum logic [1:0] {
		TLB_NONE          = 2'd0,
		TLB_PROBE         = 2'd1,
		TLB_READ          = 2'd2,
		TLB_WRITE_INDEXED = 2'd3
	} tlb_op_t;

	typedef struct packed {
		logic refill;
		logic invalid;
		logic modified;
	} tlb_exc_t;

	typedef struct packed {
		logic          miss;
		logic [4:0]    index;
		cp0_pkg::word_t entry_hi;
		cp0_pkg::word_t entry_lo0;
		cp0_pkg::word_t entry_lo1;
	} mmu_resp_t;

endpackage

`default_nettype wire

//--- design/cp0_pkg.sv
`default_nettype none

package cp0_pkg;

	typedef logic [31:0] word_t;

	typedef enum logic [4:0] {
		EXC_INT  = 5'd0,
		EXC_MOD  = 5'd1,
		EXC_TLBL = 5'd2,
		EXC_TLBS = 5'd3,
		EXC_ADEL = 5'd4,
		EXC_ADES = 5'd5,
		EXC_SYS  = 5'd8,
		EXC_BP   = 5'd9,
		EXC_RI   = 5'd10,
		EXC_OV   = 5'd12
	} exc_code_t;

	// status register, bit 31 first
	typedef struct packed {
		logic [3:0] cu;
		logic [4:0] zero0;
		logic       bev;
		logic [5:0] zero1;
		logic [7:0] im;
		logic [2:0] zero2;
		logic       um;
		logic       zero3;
		logic       erl;
		logic       exl;
		logic       ie;
	} status_t;

	// cause register, ip[7:2] mirrors the external lines
	typedef struct packed {
		logic        bd;
		logic        ti;
		logic [13:0] zero0;
		logic [7:0]  ip;
		logic        zero1;
		exc_code_t   exc_code;
		logic [1:0]  zero2;
	} cause_t;

	typedef struct packed {
		word_t   index;
		word_t   entry_lo0;
		word_t   entry_lo1;
		word_t   context_;
		word_t   page_mask;
		word_t   bad_vaddr;
		word_t   count;
		word_t   entry_hi;
		word_t   compare;
		status_t status;
		cause_t  cause;
		word_t   epc;
		word_t   prid;
		word_t   config0;
		word_t   config1;
	} cp0_regs_t;

	typedef struct packed {
		logic fetch_adel;
		logic ri;
		logic ov;
		logic trap;
		logic sys;
		logic load_adel;
		logic store_ades;
	} exc_flags_t;

	localparam word_t PRID_RESET    = 32'h0000_4220;
	localparam word_t CONFIG0_RESET = 32'h8000_0480;
	// mmu size field holds entries minus one
	localparam word_t CONFIG1_RESET = 32'h0E69_3480;
	localparam word_t EXC_VECTOR    = 32'hBFC0_0380;

	// writable bits per register
	localparam word_t WMASK_INDEX    = 32'h0000_001F;
	localparam word_t WMASK_ENTRY_LO = 32'h3FFF_FFFF;
	localparam word_t WMASK_CONTEXT  = 32'hFF80_0000;
	localparam word_t WMASK_ENTRY_HI = 32'hFFFF_E0FF;
	localparam word_t WMASK_STATUS   = 32'h1040_FF17;
	localparam word_t WMASK_CAUSE    = 32'h0000_0300;
	localparam word_t WMASK_CONFIG0  = 32'h0000_0007;

	// {number, select}
	localparam logic [7:0] REG_INDEX     = {5'd0, 3'd0};
	localparam logic [7:0] REG_ENTRY_LO0 = {5'd2, 3'd0};
	localparam logic [7:0] REG_ENTRY_LO1 = {5'd3, 3'd0};
	localparam logic [7:0] REG_CONTEXT   = {5'd4, 3'd0};
	localparam logic [7:0] REG_PAGE_MASK = {5'd5, 3'd0};
	localparam logic [7:0] REG_BAD_VADDR = {5'd8, 3'd0};
	localparam logic [7:0] REG_COUNT     = {5'd9, 3'd0};
	localparam logic [7:0] REG_ENTRY_HI  = {5'd10, 3'd0};
	localparam logic [7:0] REG_COMPARE   = {5'd11, 3'd0};
	localparam logic [7:0] REG_STATUS    = {5'd12, 3'd0};
	localparam logic [7:0] REG_CAUSE     = {5'd13, 3'd0};
	localparam logic [7:0] REG_EPC       = {5'd14, 3'd0};
	localparam logic [7:0] REG_PRID      = {5'd15, 3'd0};
	localparam logic [7:0] REG_CONFIG0   = {5'd16, 3'd0};
	localparam logic [7:0] REG_CONFIG1   = {5'd16, 3'd1};

endpackage

`default_nettype wire
